// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data word width in bits
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// Data RAM depth in words, indexed by address bits above bit 1
`define RV_RAM_WORDS 256

// Program counter value after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

    // Operations of the supported RV32I subset
    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_ORI,
        OP_ANDI,
        OP_XORI,
        OP_SLL,
        OP_SLLI,
        OP_SRL,
        OP_SRLI,
        OP_SRAI,
        OP_SLT,
        OP_SLTI,
        OP_SLTU,
        OP_SLTIU,
        OP_ADD,
        OP_ADDI,
        OP_SUB,
        OP_LW,
        OP_SW,
        OP_JAL
    } alu_op_e;

    // Result class; compares travel with the shifts
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_LOAD_STORE,
        SEL_JUMP
    } alu_sel_e;

endpackage

// File: id_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module id_decode (
    input  rv_pkg::word_t     inst_i,
    output rv_pkg::alu_op_e   aluop_o,
    output rv_pkg::alu_sel_e  alusel_o,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output logic [4:0]        shamt_o,
    output rv_pkg::word_t     imm_o,
    output logic              wreg_o
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wr;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign rs1_o   = inst_i[19:15];
    assign rs2_o   = inst_i[24:20];
    assign rd_o    = inst_i[11:7];
    assign shamt_o = inst_i[24:20];

    // x0 is never a real destination
    assign wreg_o = wr && (rd_o != '0);

    always_comb begin
        aluop_o  = rv_pkg::OP_NOP;
        alusel_o = rv_pkg::SEL_NONE;
        imm_o    = '0;
        wr       = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                imm_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
                wr    = 1'b1;
                case (funct3)
                    3'b000: {aluop_o, alusel_o} = {rv_pkg::OP_ADDI, rv_pkg::SEL_ARITH};
                    3'b010: {aluop_o, alusel_o} = {rv_pkg::OP_SLTI, rv_pkg::SEL_SHIFT};
                    3'b011: {aluop_o, alusel_o} = {rv_pkg::OP_SLTIU, rv_pkg::SEL_SHIFT};
                    3'b100: {aluop_o, alusel_o} = {rv_pkg::OP_XORI, rv_pkg::SEL_LOGIC};
                    3'b110: {aluop_o, alusel_o} = {rv_pkg::OP_ORI, rv_pkg::SEL_LOGIC};
                    3'b111: {aluop_o, alusel_o} = {rv_pkg::OP_ANDI, rv_pkg::SEL_LOGIC};
                    3'b001: begin
                        if (funct7 == 7'b0000000) begin
                            {aluop_o, alusel_o} = {rv_pkg::OP_SLLI, rv_pkg::SEL_SHIFT};
                        end else begin
                            wr = 1'b0;
                        end
                    end
                    default: begin
                        // funct7 bit 5 splits arithmetic from logical right shift
                        if (funct7 == 7'b0000000) begin
                            {aluop_o, alusel_o} = {rv_pkg::OP_SRLI, rv_pkg::SEL_SHIFT};
                        end else if (funct7 == 7'b0100000) begin
                            {aluop_o, alusel_o} = {rv_pkg::OP_SRAI, rv_pkg::SEL_SHIFT};
                        end else begin
                            wr = 1'b0;
                        end
                    end
                endcase
            end
            OPC_OP: begin
                wr = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: {aluop_o, alusel_o} = {rv_pkg::OP_ADD, rv_pkg::SEL_ARITH};
                    10'b0100000_000: {aluop_o, alusel_o} = {rv_pkg::OP_SUB, rv_pkg::SEL_ARITH};
                    10'b0000000_001: {aluop_o, alusel_o} = {rv_pkg::OP_SLL, rv_pkg::SEL_SHIFT};
                    10'b0000000_010: {aluop_o, alusel_o} = {rv_pkg::OP_SLT, rv_pkg::SEL_SHIFT};
                    10'b0000000_011: {aluop_o, alusel_o} = {rv_pkg::OP_SLTU, rv_pkg::SEL_SHIFT};
                    10'b0000000_100: {aluop_o, alusel_o} = {rv_pkg::OP_XOR, rv_pkg::SEL_LOGIC};
                    10'b0000000_101: {aluop_o, alusel_o} = {rv_pkg::OP_SRL, rv_pkg::SEL_SHIFT};
                    10'b0000000_110: {aluop_o, alusel_o} = {rv_pkg::OP_OR, rv_pkg::SEL_LOGIC};
                    10'b0000000_111: {aluop_o, alusel_o} = {rv_pkg::OP_AND, rv_pkg::SEL_LOGIC};
                    default:         wr = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    {aluop_o, alusel_o} = {rv_pkg::OP_LW, rv_pkg::SEL_LOAD_STORE};
                    imm_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
                    wr    = 1'b1;
                end
            end
            OPC_STORE: begin
                // Stores never write a register
                if (funct3 == 3'b010) begin
                    {aluop_o, alusel_o} = {rv_pkg::OP_SW, rv_pkg::SEL_LOAD_STORE};
                    imm_o = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
                end
            end
            OPC_JAL: begin
                {aluop_o, alusel_o} = {rv_pkg::OP_JAL, rv_pkg::SEL_JUMP};
                imm_o = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
                wr    = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
    end

endmodule

// File: ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  rv_pkg::alu_op_e  aluop_i,
    input  rv_pkg::alu_sel_e alusel_i,
    input  rv_pkg::word_t    reg1_i,
    input  rv_pkg::word_t    reg2_i,
    input  logic [4:0]       shamt_i,
    input  rv_pkg::word_t    imm_i,
    input  rv_pkg::word_t    link_addr_i,
    input  rv_pkg::word_t    pc_i,
    output rv_pkg::word_t    wdata_o,
    output rv_pkg::word_t    mem_addr_o,
    output rv_pkg::word_t    store_data_o,
    output rv_pkg::word_t    jump_target_o
);

    rv_pkg::word_t logic_out;
    rv_pkg::word_t shift_out;
    rv_pkg::word_t arith_out;
    rv_pkg::word_t mem_out;
    rv_pkg::word_t jump_out;

    always_comb begin
        logic_out = '0;
        if (alusel_i == rv_pkg::SEL_LOGIC) begin
            case (aluop_i)
                rv_pkg::OP_OR:   logic_out = reg1_i | reg2_i;
                rv_pkg::OP_AND:  logic_out = reg1_i & reg2_i;
                rv_pkg::OP_XOR:  logic_out = reg1_i ^ reg2_i;
                rv_pkg::OP_ORI:  logic_out = reg1_i | imm_i;
                rv_pkg::OP_ANDI: logic_out = reg1_i & imm_i;
                rv_pkg::OP_XORI: logic_out = reg1_i ^ imm_i;
                default:         logic_out = '0;
            endcase
        end
    end

    // Shifts plus set-less-than; register shift amounts use five bits only
    always_comb begin
        shift_out = '0;
        if (alusel_i == rv_pkg::SEL_SHIFT) begin
            case (aluop_i)
                rv_pkg::OP_SLL:   shift_out = reg1_i << reg2_i[4:0];
                rv_pkg::OP_SLLI:  shift_out = reg1_i << shamt_i;
                rv_pkg::OP_SRL:   shift_out = reg1_i >> reg2_i[4:0];
                rv_pkg::OP_SRLI:  shift_out = reg1_i >> shamt_i;
                rv_pkg::OP_SRAI:  shift_out = $signed(reg1_i) >>> shamt_i;
                rv_pkg::OP_SLT:   shift_out = rv_pkg::word_t'($signed(reg1_i) < $signed(reg2_i));
                rv_pkg::OP_SLTI:  shift_out = rv_pkg::word_t'($signed(reg1_i) < $signed(imm_i));
                rv_pkg::OP_SLTU:  shift_out = rv_pkg::word_t'(reg1_i < reg2_i);
                rv_pkg::OP_SLTIU: shift_out = rv_pkg::word_t'(reg1_i < imm_i);
                default:          shift_out = '0;
            endcase
        end
    end

    always_comb begin
        arith_out = '0;
        if (alusel_i == rv_pkg::SEL_ARITH) begin
            case (aluop_i)
                rv_pkg::OP_ADD:  arith_out = reg1_i + reg2_i;
                rv_pkg::OP_ADDI: arith_out = reg1_i + imm_i;
                rv_pkg::OP_SUB:  arith_out = reg1_i - reg2_i;
                default:         arith_out = '0;
            endcase
        end
    end

    // Effective address for LW and SW
    always_comb begin
        mem_out = '0;
        if (alusel_i == rv_pkg::SEL_LOAD_STORE) begin
            mem_out = reg1_i + imm_i;
        end
    end

    always_comb begin
        jump_out = '0;
        if (alusel_i == rv_pkg::SEL_JUMP) begin
            jump_out = link_addr_i;
        end
    end

    always_comb begin
        case (alusel_i)
            rv_pkg::SEL_LOGIC: wdata_o = logic_out;
            rv_pkg::SEL_SHIFT: wdata_o = shift_out;
            rv_pkg::SEL_ARITH: wdata_o = arith_out;
            rv_pkg::SEL_JUMP:  wdata_o = jump_out;
            // Load data comes from RAM later, stores write nothing
            default:           wdata_o = '0;
        endcase
    end

    assign mem_addr_o    = mem_out;
    assign store_data_o  = reg2_i;
    assign jump_target_o = pc_i + imm_i;

endmodule

// File: regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module regfile (
    input  logic              clk_i,
    input  logic              rst_i,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o
);

    rv_pkg::word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: data_ram.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module data_ram (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          we_i,
    input  logic          re_i,
    input  rv_pkg::word_t addr_i,
    input  rv_pkg::word_t wdata_i,
    output rv_pkg::word_t rdata_o
);

    localparam int IDX_W = $clog2(`RV_RAM_WORDS);

    rv_pkg::word_t    mem [`RV_RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Byte offset dropped, upper bits wrap
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rdata_o <= '0;
        end else begin
            if (we_i) begin
                mem[idx] <= wdata_i;
            end
            if (re_i) begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

// File: pc_counter.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module pc_counter (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          advance_i,
    input  logic          jump_i,
    input  rv_pkg::word_t jump_target_i,
    output rv_pkg::word_t pc_o,
    output rv_pkg::word_t link_addr_o
);

    rv_pkg::word_t pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `RV_XLEN'(`RV_RESET_PC);
        end else if (advance_i) begin
            // Taken jump replaces the sequential step
            pc_q <= jump_i ? jump_target_i : link_addr_o;
        end
    end

    assign pc_o        = pc_q;
    assign link_addr_o = pc_q + `RV_XLEN'(4);

endmodule

// File: ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm (
    input  logic              clk_i,
    input  logic              rst_i,
    input  rv_pkg::word_t     inst_i,
    input  logic              inst_valid_i,
    input  rv_pkg::alu_sel_e  alusel_i,
    input  logic              wreg_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     alu_wdata_i,
    input  rv_pkg::word_t     mem_addr_i,
    input  rv_pkg::word_t     store_data_i,
    input  rv_pkg::word_t     ram_rdata_i,
    output rv_pkg::word_t     inst_o,
    output logic              busy_o,
    output logic              ram_we_o,
    output logic              ram_re_o,
    output rv_pkg::word_t     ram_addr_o,
    output rv_pkg::word_t     ram_wdata_o,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output rv_pkg::word_t     rf_wdata_o,
    output logic              pc_advance_o,
    output logic              pc_jump_o,
    output logic              wb_valid_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECODE,
        ST_EXEC,
        ST_MEM,
        ST_WB
    } state_e;

    state_e            state_q;
    rv_pkg::word_t     inst_q;
    rv_pkg::alu_sel_e  alusel_q;
    logic              wreg_q;
    rv_pkg::reg_addr_t rd_q;
    rv_pkg::word_t     alu_wdata_q;
    rv_pkg::word_t     mem_addr_q;
    rv_pkg::word_t     store_data_q;
    logic              is_mem;
    logic              is_store;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   state_q <= inst_valid_i ? ST_DECODE : ST_IDLE;
                ST_DECODE: state_q <= ST_EXEC;
                ST_EXEC:   state_q <= ST_MEM;
                ST_MEM:    state_q <= ST_WB;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // Instruction and execute results held for the later phases
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && inst_valid_i) begin
            inst_q <= inst_i;
        end
        if (state_q == ST_EXEC) begin
            alusel_q     <= alusel_i;
            wreg_q       <= wreg_i;
            rd_q         <= rd_i;
            alu_wdata_q  <= alu_wdata_i;
            mem_addr_q   <= mem_addr_i;
            store_data_q <= store_data_i;
        end
    end

    // Opcode bit 5 tells SW from LW, even when LW targets x0
    assign is_mem   = (alusel_q == rv_pkg::SEL_LOAD_STORE);
    assign is_store = is_mem && inst_q[5];

    assign inst_o = inst_q;
    assign busy_o = (state_q != ST_IDLE);

    assign ram_we_o    = (state_q == ST_MEM) && is_store;
    assign ram_re_o    = (state_q == ST_MEM) && is_mem && !is_store;
    assign ram_addr_o  = mem_addr_q;
    assign ram_wdata_o = store_data_q;

    // RAM read data is valid in WB, one cycle after the MEM read
    assign rf_waddr_o   = rd_q;
    assign rf_wdata_o   = (is_mem && !is_store) ? ram_rdata_i : alu_wdata_q;
    assign rf_we_o      = (state_q == ST_WB) && wreg_q && (rd_q != '0);
    assign wb_valid_o   = (state_q == ST_WB);
    assign pc_advance_o = (state_q == ST_WB);
    assign pc_jump_o    = (state_q == ST_WB) && (alusel_q == rv_pkg::SEL_JUMP);

endmodule

// File: exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  rv_pkg::word_t     inst_i,
    input  logic              inst_valid_i,
    output logic              busy_o,
    output logic              wb_valid_o,
    output logic              wb_we_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::word_t     wb_data_o,
    output rv_pkg::word_t     pc_o
);

    rv_pkg::word_t     inst;
    rv_pkg::alu_op_e   aluop;
    rv_pkg::alu_sel_e  alusel;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    logic [4:0]        shamt;
    rv_pkg::word_t     imm;
    logic              wreg;
    rv_pkg::word_t     reg1;
    rv_pkg::word_t     reg2;
    rv_pkg::word_t     alu_wdata;
    rv_pkg::word_t     mem_addr;
    rv_pkg::word_t     store_data;
    rv_pkg::word_t     jump_target;
    rv_pkg::word_t     link_addr;
    logic              ram_we;
    logic              ram_re;
    rv_pkg::word_t     ram_addr;
    rv_pkg::word_t     ram_wdata;
    rv_pkg::word_t     ram_rdata;
    logic              pc_advance;
    logic              pc_jump;

    ctrl_fsm u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .alusel_i     (alusel),
        .wreg_i       (wreg),
        .rd_i         (rd),
        .alu_wdata_i  (alu_wdata),
        .mem_addr_i   (mem_addr),
        .store_data_i (store_data),
        .ram_rdata_i  (ram_rdata),
        .inst_o       (inst),
        .busy_o       (busy_o),
        .ram_we_o     (ram_we),
        .ram_re_o     (ram_re),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .rf_we_o      (wb_we_o),
        .rf_waddr_o   (wb_rd_o),
        .rf_wdata_o   (wb_data_o),
        .pc_advance_o (pc_advance),
        .pc_jump_o    (pc_jump),
        .wb_valid_o   (wb_valid_o)
    );

    id_decode u_decode (
        .inst_i   (inst),
        .aluop_o  (aluop),
        .alusel_o (alusel),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .rd_o     (rd),
        .shamt_o  (shamt),
        .imm_o    (imm),
        .wreg_o   (wreg)
    );

    // Write-back port shares the observed wb_* outputs
    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .we_i     (wb_we_o),
        .waddr_i  (wb_rd_o),
        .wdata_i  (wb_data_o),
        .rdata1_o (reg1),
        .rdata2_o (reg2)
    );

    ex_alu u_alu (
        .aluop_i       (aluop),
        .alusel_i      (alusel),
        .reg1_i        (reg1),
        .reg2_i        (reg2),
        .shamt_i       (shamt),
        .imm_i         (imm),
        .link_addr_i   (link_addr),
        .pc_i          (pc_o),
        .wdata_o       (alu_wdata),
        .mem_addr_o    (mem_addr),
        .store_data_o  (store_data),
        .jump_target_o (jump_target)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .we_i    (ram_we),
        .re_i    (ram_re),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    pc_counter u_pc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .advance_i     (pc_advance),
        .jump_i        (pc_jump),
        .jump_target_i (jump_target),
        .pc_o          (pc_o),
        .link_addr_o   (link_addr)
    );

endmodule

// File: tb_exec_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_exec_core;

    localparam int NUM_RECS   = 38;
    localparam int REC_WORDS  = 5;
    localparam int TABLE_SIZE = NUM_RECS * REC_WORDS;
    localparam int WAIT_LIMIT = 20;

    logic              clk_i;
    logic              rst_i;
    rv_pkg::word_t     inst_i;
    logic              inst_valid_i;
    logic              busy_o;
    logic              wb_valid_o;
    logic              wb_we_o;
    rv_pkg::reg_addr_t wb_rd_o;
    rv_pkg::word_t     wb_data_o;
    rv_pkg::word_t     pc_o;

    // Each record holds the instruction, write flag, rd, write-back data and PC after
    logic [31:0] pattern_mem [TABLE_SIZE];

    int    errors;
    int    timeouts;
    string ctx;

    exec_core_top uut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .busy_o       (busy_o),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .pc_o         (pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: %s = 0x%h, expected 0x%h", ctx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input rv_pkg::reg_addr_t got,
                             input rv_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: %s = 0x%h, expected 0x%h", ctx, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: %s = 0x%h, expected 0x%h", ctx, name, got, exp);
            errors++;
        end
    endtask

    // Samples on falling edges, where the DUT outputs are settled
    task automatic wait_wb_pulse(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (wb_valid_o) begin
                seen = 1'b1;
            end
            cycles++;
        end
        if (!seen) begin
            $display("%s: no write-back pulse arrived within %0d cycles", ctx, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic wait_idle(output bit idle);
        int cycles;
        idle   = 1'b0;
        cycles = 0;
        while (!idle && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (!busy_o) begin
                idle = 1'b1;
            end
            cycles++;
        end
        if (!idle) begin
            $display("%s: the core stayed busy for %0d cycles", ctx, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    task automatic run_record(input int r);
        rv_pkg::word_t     inst;
        logic              exp_we;
        rv_pkg::reg_addr_t exp_rd;
        rv_pkg::word_t     exp_data;
        rv_pkg::word_t     exp_pc;
        bit                ok;
        inst     = pattern_mem[r * REC_WORDS];
        exp_we   = pattern_mem[r * REC_WORDS + 1][0];
        exp_rd   = pattern_mem[r * REC_WORDS + 2][4:0];
        exp_data = pattern_mem[r * REC_WORDS + 3];
        exp_pc   = pattern_mem[r * REC_WORDS + 4];
        ctx      = $sformatf("record %0d (inst 0x%h)", r, inst);

        // One-cycle strobe, accepted on the next edge since the core is idle
        @(posedge clk_i);
        inst_i       <= inst;
        inst_valid_i <= 1'b1;
        @(posedge clk_i);
        inst_valid_i <= 1'b0;

        wait_wb_pulse(ok);
        if (ok) begin
            check_bit("wb_we_o", wb_we_o, exp_we);
            // rd is only meaningful when a register is written
            if (exp_we) begin
                check_reg("wb_rd_o", wb_rd_o, exp_rd);
            end
            check_word("wb_data_o", wb_data_o, exp_data);
            wait_idle(ok);
            if (ok) begin
                check_word("pc_o", pc_o, exp_pc);
            end
        end
    endtask

    initial begin
        bit loaded;
        errors       = 0;
        timeouts     = 0;
        ctx          = "reset";
        rst_i        <= 1'b1;
        inst_i       <= '0;
        inst_valid_i <= 1'b0;

        for (int i = 0; i < TABLE_SIZE; i++) begin
            pattern_mem[i] = 32'hbad0_0000 | 32'(i);
        end
        $readmemh("exec_patterns.hex", pattern_mem);
        loaded = (pattern_mem[TABLE_SIZE-1] !== (32'hbad0_0000 | 32'(TABLE_SIZE-1)));
        if (!loaded) begin
            $display("The pattern file holds fewer than %0d records", NUM_RECS);
            errors++;
        end

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("wb_valid_o", wb_valid_o, 1'b0);
        check_bit("wb_we_o", wb_we_o, 1'b0);
        check_word("pc_o", pc_o, `RV_RESET_PC);

        if (loaded) begin
            for (int r = 0; r < NUM_RECS && timeouts == 0; r++) begin
                run_record(r);
            end
        end

        $display("Value mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: exec_patterns.hex
// Columns: instruction, write flag, rd, write-back data, PC after the instruction
// Expected values follow RV32I semantics, PC starts at 0
5A506093 1 01 000005A5 00000004  // ori   x1, x0, 0x5a5
0F00F113 1 02 000000A0 00000008  // andi  x2, x1, 0x0f0
FFF0C193 1 03 FFFFFA5A 0000000C  // xori  x3, x1, -1
00316233 1 04 FFFFFAFA 00000010  // or    x4, x2, x3
001272B3 1 05 000000A0 00000014  // and   x5, x4, x1
0041C333 1 06 000000A0 00000018  // xor   x6, x3, x4
00419393 1 07 FFFFA5A0 0000001C  // slli  x7, x3, 4
0081D413 1 08 00FFFFFA 00000020  // srli  x8, x3, 8
4081D493 1 09 FFFFFFFA 00000024  // srai  x9, x3, 8
02400513 1 0A 00000024 00000028  // addi  x10, x0, 36
00A095B3 1 0B 00005A50 0000002C  // sll   x11, x1, x10 (amount 36 uses 4)
00A1D633 1 0C 0FFFFFA5 00000030  // srl   x12, x3, x10
0011A6B3 1 0D 00000001 00000034  // slt   x13, x3, x1
0011B733 1 0E 00000000 00000038  // sltu  x14, x3, x1
0051A793 1 0F 00000001 0000003C  // slti  x15, x3, 5
0051B813 1 10 00000000 00000040  // sltiu x16, x3, 5
FFF0B893 1 11 00000001 00000044  // sltiu x17, x1, -1
FFF0A913 1 12 00000000 00000048  // slti  x18, x1, -1
FFF00993 1 13 FFFFFFFF 0000004C  // addi  x19, x0, -1
00298A13 1 14 00000001 00000050  // addi  x20, x19, 2 (wraps)
00998AB3 1 15 FFFFFFF9 00000054  // add   x21, x19, x9
0019DB13 1 16 7FFFFFFF 00000058  // srli  x22, x19, 1
014B0BB3 1 17 80000000 0000005C  // add   x23, x22, x20 (wraps)
413A0C33 1 18 00000002 00000060  // sub   x24, x20, x19
41400CB3 1 19 FFFFFFFF 00000064  // sub   x25, x0, x20
00412823 0 00 00000000 00000068  // sw    x4, 16(x2)
FF712E23 0 00 00000000 0000006C  // sw    x23, -4(x2)
01012D03 1 1A FFFFFAFA 00000070  // lw    x26, 16(x2)
FFC12D83 1 1B 80000000 00000074  // lw    x27, -4(x2)
00002E03 1 1C 00000000 00000078  // lw    x28, 0(x0)
010000EF 1 01 0000007C 00000088  // jal   x1, +16
FF9FF2EF 1 05 0000008C 00000080  // jal   x5, -8
0080006F 0 00 00000084 00000088  // jal   x0, +8
00508013 0 00 00000081 0000008C  // addi  x0, x1, 5
00000EB3 1 1D 00000000 00000090  // add   x29, x0, x0
00900F33 1 1E FFFFFFFA 00000094  // add   x30, x0, x9
12345FB7 0 1F 00000000 00000098  // lui   x31 (not supported)
00508FB3 1 1F 00000108 0000009C  // add   x31, x1, x5

// File: build.f
+incdir+.
rv_pkg.sv
id_decode.sv
ex_alu.sv
regfile.sv
data_ram.sv
pc_counter.sv
ctrl_fsm.sv
exec_core_top.sv
tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_exec_core -o sim_exec_core

output=$(./obj_dir/sim_exec_core)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
